// File: axis_mux_config.svh
// ****************************************************************************
// stream multiplexer configuration
// input count and beat field widths shared by the packages, the RTL and the
// testbench
// ****************************************************************************

`ifndef AXIS_MUX_CONFIG_SVH
`define AXIS_MUX_CONFIG_SVH

// number of input streams
`define MUX_S_COUNT 4

// beat field widths
`define MUX_DATA_WIDTH 32
// one keep bit per data byte
`define MUX_KEEP_WIDTH 4
`define MUX_USER_WIDTH 1

`endif

// File: axis_pkg.sv
// ****************************************************************************
// stream types
// beat layout and output register stage states
// ****************************************************************************

`include "axis_mux_config.svh"

package axis_pkg;

    // one transfer on a valid/ready stream
    typedef struct packed {
        logic [`MUX_DATA_WIDTH-1:0] data;
        logic [`MUX_KEEP_WIDTH-1:0] keep;
        logic                       last;
        logic [`MUX_USER_WIDTH-1:0] user;
    } axis_beat_t;

    // occupancy of the two-entry output stage
    typedef enum logic [1:0] {
        // nothing held
        SKID_EMPTY = 2'd0,
        // output register full
        SKID_ONE   = 2'd1,
        // output and spare register full
        SKID_TWO   = 2'd2
    } skid_state_e;

endpackage

// File: arb_pkg.sv
// ****************************************************************************
// arbiter types
// grant passed from the round-robin arbiter to the multiplexer
// ****************************************************************************

`include "axis_mux_config.svh"

package arb_pkg;

    // width of an input index
    localparam int ARB_IDX_W = $clog2(`MUX_S_COUNT);

    // index is meaningful only while valid is set,
    // but keeps the last granted input after the grant drops
    typedef struct packed {
        logic                 valid;
        logic [ARB_IDX_W-1:0] index;
    } arb_grant_t;

endpackage

// File: arbiter.sv
// ****************************************************************************
// round-robin arbiter
// registered grant, held until the granted input acknowledges, then passed
// on to the next requester after it
// ****************************************************************************

`timescale 1ns/10ps

`include "axis_mux_config.svh"

module arbiter (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [`MUX_S_COUNT-1:0]   request,
    input  logic [`MUX_S_COUNT-1:0]   acknowledge,
    output arb_pkg::arb_grant_t       grant
);

    import arb_pkg::*;

    localparam int S_COUNT = `MUX_S_COUNT;

    arb_grant_t grant_d;
    logic       any_request;
    logic       grant_free;

    // first requester after last, wrapping around
    // the search runs from far to near so the nearest one wins
    function automatic logic [ARB_IDX_W-1:0] rr_pick(
        input logic [S_COUNT-1:0]   req,
        input logic [ARB_IDX_W-1:0] last
    );
        logic [ARB_IDX_W-1:0] pick;
        int unsigned          cand;
        pick = last;
        for (int k = S_COUNT; k >= 1; k--) begin
            cand = (int'(last) + k) % S_COUNT;
            if (req[cand]) begin
                pick = ARB_IDX_W'(cand);
            end
        end
        return pick;
    endfunction

    assign any_request = |request;

    // no grant held, or the holder finishes its packet on this edge
    assign grant_free = !grant.valid || acknowledge[grant.index];

    always_comb begin
        grant_d = grant;
        if (grant_free) begin
            grant_d.valid = any_request;
            if (any_request) begin
                grant_d.index = rr_pick(request, grant.index);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            grant.valid <= 1'b0;
            // search starts at input 0 after reset
            grant.index <= ARB_IDX_W'(S_COUNT - 1);
        end else begin
            grant <= grant_d;
        end
    end

    // the grant must not move while its packet is still in flight
    a_grant_held: assert property (
        @(posedge clk) disable iff (rst)
        grant.valid && !acknowledge[grant.index]
        |=> grant.valid && grant.index == $past(grant.index)
    );

    // the multiplexer acknowledges only the granted input
    a_ack_granted: assert property (
        @(posedge clk) disable iff (rst)
        acknowledge != '0
        |-> grant.valid && acknowledge == (S_COUNT'(1) << grant.index)
    );

endmodule

// File: axis_skid_reg.sv
// ****************************************************************************
// two-entry output register stage
// output register plus spare register, all outputs registered, ready back
// to the source registered from an early ready term
// ****************************************************************************

`timescale 1ns/10ps

module axis_skid_reg (
    input  logic                  clk,
    input  logic                  rst,
    input  axis_pkg::axis_beat_t  in_beat,
    input  logic                  in_valid,
    output logic                  in_ready,
    output axis_pkg::axis_beat_t  m_beat,
    output logic                  m_valid,
    input  logic                  m_ready
);

    import axis_pkg::*;

    skid_state_e state_q;
    skid_state_e state_d;

    // spare register payload
    axis_beat_t  spare_beat;

    // datapath moves
    logic        store_in_to_out;
    logic        store_in_to_spare;
    logic        store_spare_to_out;

    logic        in_ready_early;

    assign m_valid = (state_q != SKID_EMPTY);

    // ready next cycle if the sink drains, or if the spare register
    // cannot fill this cycle (output empty or nothing arriving)
    assign in_ready_early = m_ready ||
        (state_q != SKID_TWO && (state_q == SKID_EMPTY || !in_valid));

    always_comb begin
        state_d            = state_q;
        store_in_to_out    = 1'b0;
        store_in_to_spare  = 1'b0;
        store_spare_to_out = 1'b0;

        if (in_ready) begin
            if (m_ready || state_q == SKID_EMPTY) begin
                // output free or draining, load it straight from the input
                state_d         = in_valid ? SKID_ONE : SKID_EMPTY;
                store_in_to_out = in_valid;
            end else begin
                // output stalled, park the arriving beat
                state_d           = in_valid ? SKID_TWO : SKID_ONE;
                store_in_to_spare = in_valid;
            end
        end else if (m_ready) begin
            // input closed, refill output from the spare register
            state_d            = (state_q == SKID_TWO) ? SKID_ONE : SKID_EMPTY;
            store_spare_to_out = (state_q == SKID_TWO);
        end
    end

    // control state
    always_ff @(posedge clk) begin
        if (rst) begin
            state_q  <= SKID_EMPTY;
            in_ready <= 1'b0;
        end else begin
            state_q  <= state_d;
            in_ready <= in_ready_early;
        end
    end

    // payload registers
    always_ff @(posedge clk) begin
        if (store_in_to_out) begin
            m_beat <= in_beat;
        end else if (store_spare_to_out) begin
            m_beat <= spare_beat;
        end

        if (store_in_to_spare) begin
            spare_beat <= in_beat;
        end
    end

    // a stalled beat stays put until the sink takes it
    a_out_stable: assert property (
        @(posedge clk) disable iff (rst)
        m_valid && !m_ready |=> m_valid && $stable(m_beat)
    );

    // the registered ready never opens with both registers occupied
    a_ready_not_full: assert property (
        @(posedge clk) disable iff (rst)
        in_ready |-> state_q != SKID_TWO
    );

endmodule

// File: axis_arb_mux.sv
// ****************************************************************************
// arbitrated stream multiplexer
// four packet streams share one output, one whole packet at a time, chosen
// round robin and passed through a two-entry output register stage
// ****************************************************************************

`timescale 1ns/10ps

`include "axis_mux_config.svh"

module axis_arb_mux (
    input  logic                      clk,
    input  logic                      rst,
    input  axis_pkg::axis_beat_t      s_beat [`MUX_S_COUNT],
    input  logic [`MUX_S_COUNT-1:0]   s_valid,
    output logic [`MUX_S_COUNT-1:0]   s_ready,
    output axis_pkg::axis_beat_t      m_beat,
    output logic                      m_valid,
    input  logic                      m_ready
);

    import axis_pkg::*;
    import arb_pkg::*;

    localparam int S_COUNT = `MUX_S_COUNT;

    logic [S_COUNT-1:0] request;
    logic [S_COUNT-1:0] acknowledge;
    logic [S_COUNT-1:0] grant_onehot;
    logic [S_COUNT-1:0] s_last;
    arb_grant_t         grant;

    // beat towards the output stage
    axis_beat_t         in_beat;
    logic               in_valid;
    logic               in_ready;

    always_comb begin
        for (int i = 0; i < S_COUNT; i++) begin
            s_last[i] = s_beat[i].last;
        end
    end

    assign grant_onehot = grant.valid ? (S_COUNT'(1) << grant.index) : '0;

    // the current holder does not compete again until it lets go
    assign request = s_valid & ~grant_onehot;

    // last beat of the granted packet accepted on this edge
    assign acknowledge = grant_onehot & s_valid & s_ready & s_last;

    arbiter i_arbiter (
        .clk         (clk),
        .rst         (rst),
        .request     (request),
        .acknowledge (acknowledge),
        .grant       (grant)
    );

    // select the granted input
    assign in_beat  = s_beat[grant.index];
    assign in_valid = s_valid[grant.index] && grant.valid && in_ready;

    // registered ready goes back to the granted input only
    assign s_ready = in_ready ? grant_onehot : '0;

    axis_skid_reg i_axis_skid_reg (
        .clk      (clk),
        .rst      (rst),
        .in_beat  (in_beat),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .m_beat   (m_beat),
        .m_valid  (m_valid),
        .m_ready  (m_ready)
    );

    // packets never share the input side
    a_one_ready: assert property (
        @(posedge clk) disable iff (rst)
        $onehot0(s_ready)
    );

endmodule

// File: tb_axis_arb_mux.sv
// ****************************************************************************
// testbench for the arbitrated stream multiplexer
// random packet sources, a sink with random back-pressure and a scoreboard
// for beat contents, packet order and round-robin order
// ****************************************************************************

`timescale 1ns/10ps

`include "axis_mux_config.svh"

module tb_axis_arb_mux;

    import axis_pkg::*;

    localparam int S_COUNT     = `MUX_S_COUNT;
    localparam int KEEP_W      = `MUX_KEEP_WIDTH;
    localparam int USER_W      = `MUX_USER_WIDTH;
    localparam int PKT_COUNT   = 40;
    localparam int MAX_BEATS   = 6;
    localparam int TOTAL_PKTS  = S_COUNT * PKT_COUNT;
    localparam int TIMEOUT_CYC = 20000;

    logic               clk;
    logic               rst;
    axis_beat_t         s_beat [S_COUNT];
    logic [S_COUNT-1:0] s_valid;
    logic [S_COUNT-1:0] s_ready;
    axis_beat_t         m_beat;
    logic               m_valid;
    logic               m_ready;

    logic [31:0]        lcg_state;
    int                 cycle;

    // source state
    int                 pkt_num [S_COUNT];
    int                 beat_num [S_COUNT];
    int                 pkt_len [S_COUNT];
    int                 gap [S_COUNT];
    logic [S_COUNT-1:0] taken;
    logic [S_COUNT-1:0] in_pkt;

    // reference model
    axis_beat_t         sent_q [S_COUNT][$];
    int                 last_order [$];
    int                 rr_last;
    logic               rr_wait;
    int                 rr_expect;

    // sink state
    logic               out_active;
    int                 out_src;
    logic               stall_q;
    axis_beat_t         held_beat;
    int                 pkts_done;
    int                 reset_edges;
    int                 after_reset;

    int                 err_value;
    int                 err_order;
    int                 err_other;

    axis_arb_mux i_axis_arb_mux (
        .clk     (clk),
        .rst     (rst),
        .s_beat  (s_beat),
        .s_valid (s_valid),
        .s_ready (s_ready),
        .m_beat  (m_beat),
        .m_valid (m_valid),
        .m_ready (m_ready)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // upper bits only, the low ones of an LCG cycle quickly
    function automatic int rand_below(input int n);
        logic [31:0] r;
        r = next_rand();
        return int'(r[30:8] % n);
    endfunction

    // first source with s_valid in the span after from, wrapping around
    function automatic int first_valid(input int from, input int span);
        int idx;
        for (int k = 1; k <= span; k++) begin
            idx = (from + k) % S_COUNT;
            if (s_valid[idx]) begin
                return idx;
            end
        end
        return -1;
    endfunction

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            err_value++;
            $display("ERR %s: got %h expected %h", name, got, exp);
        end
    endtask

    // runs on the falling edge
    task automatic drive_sources();
        for (int i = 0; i < S_COUNT; i++) begin
            if (taken[i]) begin
                taken[i]   = 1'b0;
                s_valid[i] = 1'b0;
                if (s_beat[i].last) begin
                    pkt_num[i]++;
                    beat_num[i] = 0;
                    gap[i]      = rand_below(4);
                end else begin
                    beat_num[i]++;
                end
            end
            if (!s_valid[i] && pkt_num[i] < PKT_COUNT) begin
                if (gap[i] > 0) begin
                    gap[i]--;
                end else begin
                    if (beat_num[i] == 0) begin
                        pkt_len[i] = 1 + rand_below(MAX_BEATS);
                    end
                    // source, packet and beat number identify the beat
                    s_beat[i].data = {8'(i), 8'(pkt_num[i]), 16'(beat_num[i])};
                    s_beat[i].keep = KEEP_W'(rand_below(1 << KEEP_W));
                    s_beat[i].last = (beat_num[i] == pkt_len[i] - 1);
                    s_beat[i].user = USER_W'(rand_below(1 << USER_W));
                    s_valid[i]     = 1'b1;
                end
            end
        end
    endtask

    // input handshakes feed the queues and the round-robin expectation
    task automatic track_inputs();
        logic acked;
        acked = 1'b0;
        for (int i = 0; i < S_COUNT; i++) begin
            if (s_valid[i] && s_ready[i]) begin
                taken[i] = 1'b1;
                sent_q[i].push_back(s_beat[i]);
                if (!in_pkt[i]) begin
                    if (rr_expect < 0) begin
                        err_order++;
                        $display("packet from source %0d started with no grant due", i);
                    end else if (i != rr_expect) begin
                        err_order++;
                        $display("round robin gave source %0d, source %0d was due",
                                 i, rr_expect);
                    end
                    rr_expect = -1;
                end
                in_pkt[i] = !s_beat[i].last;
                if (s_beat[i].last) begin
                    last_order.push_back(i);
                    // the finishing source does not request on this edge
                    rr_last   = i;
                    rr_expect = first_valid(i, S_COUNT - 1);
                    rr_wait   = (rr_expect < 0);
                    acked     = 1'b1;
                end
            end
        end
        if (rr_wait && !acked) begin
            rr_expect = first_valid(rr_last, S_COUNT);
            rr_wait   = (rr_expect < 0);
        end
    endtask

    task automatic check_output();
        axis_beat_t exp;
        int         src;
        // a stalled beat has to stay on the output
        if (stall_q) begin
            check_value("m_valid", 64'(m_valid), 64'(1));
            check_value("m_beat", 64'(m_beat), 64'(held_beat));
        end
        stall_q   = m_valid && !m_ready;
        held_beat = m_beat;
        if (m_valid && m_ready) begin
            src = int'(m_beat.data[31:24]);
            if (src >= S_COUNT) begin
                err_other++;
                $display("output beat names an unknown source %0d", src);
            end else if (sent_q[src].size() == 0) begin
                err_other++;
                $display("output beat from source %0d was never sent", src);
            end else begin
                exp = sent_q[src].pop_front();
                check_value("m_beat.data", 64'(m_beat.data), 64'(exp.data));
                check_value("m_beat.keep", 64'(m_beat.keep), 64'(exp.keep));
                check_value("m_beat.last", 64'(m_beat.last), 64'(exp.last));
                check_value("m_beat.user", 64'(m_beat.user), 64'(exp.user));
                if (out_active && src != out_src) begin
                    err_order++;
                    $display("beat from source %0d inside a packet from source %0d",
                             src, out_src);
                end
                out_src    = src;
                out_active = !m_beat.last;
                if (m_beat.last) begin
                    pkts_done++;
                    if (last_order.size() == 0 || last_order[0] != src) begin
                        err_order++;
                        $display("packet from source %0d ended out of input order", src);
                    end
                    if (last_order.size() != 0) begin
                        void'(last_order.pop_front());
                    end
                end
            end
        end
    endtask

    // DUT outputs only move on the rising edge, so the pre-edge values are sampled here
    always @(posedge clk) begin
        if (rst) begin
            // registers are still unknown before the first reset edge
            if (reset_edges > 0) begin
                check_value("m_valid", 64'(m_valid), 64'(0));
                check_value("s_ready", 64'(s_ready), 64'(0));
            end
            reset_edges++;
            after_reset = 2;
        end else begin
            // last reset cycle and first cycle out of reset
            if (after_reset > 0) begin
                check_value("m_valid", 64'(m_valid), 64'(0));
                check_value("s_ready", 64'(s_ready), 64'(0));
                after_reset--;
            end
            if (!$onehot0(s_ready)) begin
                err_other++;
                $display("more than one s_ready high at once: %b", s_ready);
            end
            track_inputs();
            check_output();
        end
    end

    initial begin
        lcg_state = 32'h6b6b_b9cf;
        rst       = 1'b1;
        s_valid   = '0;
        m_ready   = 1'b0;
        for (int i = 0; i < S_COUNT; i++) begin
            s_beat[i]   = '0;
            pkt_num[i]  = 0;
            beat_num[i] = 0;
            pkt_len[i]  = 1;
            gap[i]      = 0;
        end
        taken             = '0;
        in_pkt            = '0;
        // arbiter search starts at input 0 after reset
        rr_last           = S_COUNT - 1;
        rr_wait           = 1'b1;
        rr_expect         = -1;
        out_active        = 1'b0;
        out_src           = 0;
        stall_q           = 1'b0;
        held_beat         = '0;
        pkts_done         = 0;
        reset_edges       = 0;
        after_reset       = 0;
        err_value         = 0;
        err_order         = 0;
        err_other         = 0;

        repeat (16) @(negedge clk);
        rst = 1'b0;

        cycle = 0;
        while (pkts_done < TOTAL_PKTS && cycle < TIMEOUT_CYC) begin
            @(negedge clk);
            drive_sources();
            // sink stalls roughly 30% of the cycles
            m_ready = (rand_below(10) >= 3);
            cycle++;
        end

        if (pkts_done != TOTAL_PKTS) begin
            err_other++;
            $display("timeout after %0d cycles, %0d of %0d packets received",
                     cycle, pkts_done, TOTAL_PKTS);
        end
        for (int i = 0; i < S_COUNT; i++) begin
            if (sent_q[i].size() != 0) begin
                err_other++;
                $display("%0d beats from source %0d never reached the output",
                         sent_q[i].size(), i);
            end
        end

        $display("errors: value %0d, order %0d, other %0d", err_value, err_order, err_other);
        if (err_value + err_order + err_other == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: tb.f
+incdir+.
axis_pkg.sv
arb_pkg.sv
arbiter.sv
axis_skid_reg.sv
axis_arb_mux.sv
tb_axis_arb_mux.sv

// File: Makefile
SIM       := verilator
SIM_FLAGS := --binary --timing --assert -Wno-fatal
TOP       := tb_axis_arb_mux
FILE_LIST := tb.f
BUILD_DIR := obj_dir
PASS_MSG  := All tests passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILE_LIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
